/* Makefile */
TOP := tb_alu_issue

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q ">>> FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q ">>> PASS" sim.log; then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* alu_exec.sv */
module alu_exec (
    input  logic              clk,
    input  logic              rst,
    input  logic              ex_valid_i,
    input  ooo_pkg::alu_uop_t ex_uop_i,
    input  ooo_pkg::word_t    opa_i,
    input  ooo_pkg::word_t    opb_i,
    output ooo_pkg::wb_bus_t  wb_o,
    output ooo_pkg::word_t    wb_pc_o    // trace only
);
    import ooo_pkg::*;

    word_t      result;
    logic [4:0] shamt;

    logic       wb_valid_q;
    prf_num_t   wb_tag_q;
    word_t      wb_data_q;
    word_t      wb_pc_q;

    assign shamt = opb_i[4:0];

    always_comb begin
        case (ex_uop_i.alu_op)
            ALU_ADD:  result = opa_i + opb_i;
            ALU_SUB:  result = opa_i - opb_i;
            ALU_AND:  result = opa_i & opb_i;
            ALU_OR:   result = opa_i | opb_i;
            ALU_XOR:  result = opa_i ^ opb_i;
            ALU_NOR:  result = ~(opa_i | opb_i);
            ALU_SLL:  result = opa_i << shamt;
            ALU_SRL:  result = opa_i >> shamt;
            ALU_SRA:  result = word_t'($signed(opa_i) >>> shamt);
            ALU_SLT:  result = ($signed(opa_i) < $signed(opb_i)) ? 32'd1 : 32'd0;
            ALU_SLTU: result = (opa_i < opb_i) ? 32'd1 : 32'd0;
            ALU_LUI:  result = opb_i << 16;
            default:  result = '0;
        endcase
    end

    // no broadcast for ops that write nothing
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= ex_valid_i && ex_uop_i.wen_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid_i) begin
            wb_tag_q  <= ex_uop_i.prf_rd;
            wb_data_q <= result;
            wb_pc_q   <= ex_uop_i.pc;
        end
    end

    assign wb_o.valid = wb_valid_q;
    assign wb_o.tag   = wb_tag_q;
    assign wb_o.data  = wb_data_q;
    assign wb_pc_o    = wb_pc_q;

endmodule

/* alu_issue_props.sv */
module alu_issue_props (
    input logic                            clk,
    input logic                            rst,
    input logic [ooo_pkg::IQ_DEPTH-1:0]    ent_valid_i,
    input logic                            issue_valid_i,
    input logic                            iq_full_i,
    input ooo_pkg::wb_bus_t                wb_a_i,   // ALU writeback
    input ooo_pkg::wb_bus_t                wb_b_i    // external writeback
);
    import ooo_pkg::*;

    // at most one slot leaves the queue per cycle
    a_one_select: assert property (@(posedge clk) disable iff (rst)
        $onehot0($past(ent_valid_i) & ~ent_valid_i))
        else $error("more than one queue slot selected");

    // an issued op came from a slot that was valid
    a_no_issue_empty: assert property (@(posedge clk) disable iff (rst)
        issue_valid_i |-> $past(|ent_valid_i))
        else $error("issue from an empty queue");

    a_no_tag_clash: assert property (@(posedge clk) disable iff (rst)
        !(wb_a_i.valid && wb_b_i.valid && (wb_a_i.tag == wb_b_i.tag)))
        else $error("ALU and external writeback hit the same tag");

    a_empty_after_reset: assert property (@(posedge clk)
        $past(rst) |-> !iq_full_i)
        else $error("queue full right after reset");

endmodule

bind issue_queue alu_issue_props u_props (
    .clk           (clk),
    .rst           (rst),
    .ent_valid_i   (ent_valid),
    .issue_valid_i (issue_valid_o),
    .iq_full_i     (iq_full_o),
    .wb_a_i        (wb_a_i),
    .wb_b_i        (wb_b_i)
);

/* alu_issue_top.sv */
module alu_issue_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              dispatch_valid_i,
    input  ooo_pkg::alu_uop_t dispatch_uop_i,
    input  ooo_pkg::wb_bus_t  ext_wb_i,         // load unit and others
    output logic              iq_full_o,
    output ooo_pkg::wb_bus_t  wb_o,
    output ooo_pkg::word_t    wb_pc_o
);
    import ooo_pkg::*;

    logic     iq_full;
    logic     disp_accept;
    logic     src1_rdy;
    logic     src2_rdy;
    logic     issue_valid;
    alu_uop_t issue_uop;
    logic     ex_valid;
    alu_uop_t ex_uop;
    word_t    opa;
    word_t    opb;
    wb_bus_t  alu_wb;

    // busy bit only set for ops the queue takes
    assign disp_accept = dispatch_valid_i && !iq_full;

    issue_queue u_iq (
        .clk              (clk),
        .rst              (rst),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_uop_i   (dispatch_uop_i),
        .src1_rdy_i       (src1_rdy),
        .src2_rdy_i       (src2_rdy),
        .wb_a_i           (alu_wb),     // own writeback fed back for wakeup
        .wb_b_i           (ext_wb_i),
        .iq_full_o        (iq_full),
        .issue_valid_o    (issue_valid),
        .issue_uop_o      (issue_uop)
    );

    prf_read u_rr (
        .clk           (clk),
        .rst           (rst),
        .disp_valid_i  (disp_accept),
        .disp_rs1_i    (dispatch_uop_i.prf_rs1),
        .disp_rs2_i    (dispatch_uop_i.prf_rs2),
        .disp_rd_i     (dispatch_uop_i.prf_rd),
        .disp_wen_rd_i (dispatch_uop_i.wen_rd),
        .src1_rdy_o    (src1_rdy),
        .src2_rdy_o    (src2_rdy),
        .issue_valid_i (issue_valid),
        .issue_uop_i   (issue_uop),
        .wb_a_i        (alu_wb),
        .wb_b_i        (ext_wb_i),
        .ex_valid_o    (ex_valid),
        .ex_uop_o      (ex_uop),
        .opa_o         (opa),
        .opb_o         (opb)
    );

    alu_exec u_alu (
        .clk        (clk),
        .rst        (rst),
        .ex_valid_i (ex_valid),
        .ex_uop_i   (ex_uop),
        .opa_i      (opa),
        .opb_i      (opb),
        .wb_o       (alu_wb),
        .wb_pc_o    (wb_pc_o)
    );

    assign iq_full_o = iq_full;
    assign wb_o      = alu_wb;

endmodule

/* flist.f */
ooo_pkg.sv
iq_entry.sv
issue_queue.sv
prf_read.sv
alu_exec.sv
alu_issue_top.sv
alu_issue_props.sv
tb_alu_issue.sv

/* iq_entry.sv */
module iq_entry (
    input  logic              clk,
    input  logic              rst,
    input  logic              wen_i,       // allocate this slot
    input  ooo_pkg::alu_uop_t uop_i,
    input  logic              rs1_rdy_i,   // busy table lookup at dispatch
    input  logic              rs2_rdy_i,
    input  logic              selected_i,  // picked by select this cycle
    input  ooo_pkg::wb_bus_t  wb_a_i,
    input  ooo_pkg::wb_bus_t  wb_b_i,
    output ooo_pkg::alu_uop_t uop_o,
    output logic              valid_o,
    output logic              rdy_o
);
    import ooo_pkg::*;

    alu_uop_t uop_q;
    logic     valid_q;
    logic     rs1_rdy_q;
    logic     rs2_rdy_q;
    logic     rs1_rdy_in;
    logic     rs2_rdy_in;
    logic     rs1_wake;
    logic     rs2_wake;

    // a source that reads no register never waits
    assign rs1_rdy_in = !uop_i.r_rs1 || rs1_rdy_i;
    assign rs2_rdy_in = !uop_i.r_rs2 || rs2_rdy_i;

    // tag match against the stored sources
    assign rs1_wake = wb_hit(wb_a_i, wb_b_i, uop_q.prf_rs1);
    assign rs2_wake = wb_hit(wb_a_i, wb_b_i, uop_q.prf_rs2);

    always_ff @(posedge clk) begin
        if (wen_i) begin
            uop_q <= uop_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (wen_i) begin
            valid_q <= 1'b1;
        end else if (selected_i) begin
            valid_q <= 1'b0;   // slot is free again
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rs1_rdy_q <= 1'b0;
            rs2_rdy_q <= 1'b0;
        end else if (wen_i) begin
            rs1_rdy_q <= rs1_rdy_in;
            rs2_rdy_q <= rs2_rdy_in;
        end else if (selected_i) begin
            rs1_rdy_q <= 1'b0;
            rs2_rdy_q <= 1'b0;
        end else if (valid_q) begin
            // wakeup while waiting in the queue
            if (!rs1_rdy_q && rs1_wake) begin
                rs1_rdy_q <= 1'b1;
            end
            if (!rs2_rdy_q && rs2_wake) begin
                rs2_rdy_q <= 1'b1;
            end
        end
    end

    assign uop_o   = uop_q;
    assign valid_o = valid_q;
    assign rdy_o   = valid_q && rs1_rdy_q && rs2_rdy_q;

endmodule

/* issue_queue.sv */
module issue_queue (
    input  logic              clk,
    input  logic              rst,
    input  logic              dispatch_valid_i,
    input  ooo_pkg::alu_uop_t dispatch_uop_i,
    input  logic              src1_rdy_i,
    input  logic              src2_rdy_i,
    input  ooo_pkg::wb_bus_t  wb_a_i,        // ALU writeback
    input  ooo_pkg::wb_bus_t  wb_b_i,        // external writeback
    output logic              iq_full_o,
    output logic              issue_valid_o,
    output ooo_pkg::alu_uop_t issue_uop_o
);
    import ooo_pkg::*;

    alu_uop_t            ent_uop [IQ_DEPTH];
    logic [IQ_DEPTH-1:0] ent_valid;
    logic [IQ_DEPTH-1:0] ent_rdy;
    logic [IQ_DEPTH-1:0] ent_wen;
    logic [IQ_DEPTH-1:0] ent_sel;

    logic     full;
    logic     accept;
    logic     any_rdy;
    iq_idx_t  free_idx;
    iq_idx_t  sel_idx;

    logic     issue_valid_q;
    alu_uop_t issue_uop_q;

    // priority encoder, lowest set bit wins
    function automatic iq_idx_t lowest_one(input logic [IQ_DEPTH-1:0] vec);
        iq_idx_t idx;
        idx = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = iq_idx_t'(i);
            end
        end
        return idx;
    endfunction

    assign full     = &ent_valid;
    assign accept   = dispatch_valid_i && !full;  // dropped when full
    assign free_idx = lowest_one(~ent_valid);

    assign any_rdy  = |ent_rdy;
    assign sel_idx  = lowest_one(ent_rdy);

    for (genvar i = 0; i < IQ_DEPTH; i++) begin : g_slot
        assign ent_wen[i] = accept && (free_idx == iq_idx_t'(i));
        assign ent_sel[i] = any_rdy && (sel_idx == iq_idx_t'(i));

        iq_entry u_entry (
            .clk        (clk),
            .rst        (rst),
            .wen_i      (ent_wen[i]),
            .uop_i      (dispatch_uop_i),
            .rs1_rdy_i  (src1_rdy_i),
            .rs2_rdy_i  (src2_rdy_i),
            .selected_i (ent_sel[i]),
            .wb_a_i     (wb_a_i),
            .wb_b_i     (wb_b_i),
            .uop_o      (ent_uop[i]),
            .valid_o    (ent_valid[i]),
            .rdy_o      (ent_rdy[i])
        );
    end

    // issue register, one op per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_valid_q <= 1'b0;
        end else begin
            issue_valid_q <= any_rdy;
        end
    end

    always_ff @(posedge clk) begin
        if (any_rdy) begin
            issue_uop_q <= ent_uop[sel_idx];
        end
    end

    assign iq_full_o     = full;
    assign issue_valid_o = issue_valid_q;
    assign issue_uop_o   = issue_uop_q;

endmodule

/* ooo_pkg.sv */
package ooo_pkg;

    // physical register file
    localparam int PRF_NUM       = 64;
    localparam int PRF_NUM_WIDTH = 6;

    // issue queue
    localparam int IQ_DEPTH      = 8;
    localparam int IQ_IDX_WIDTH  = 3;

    typedef logic [PRF_NUM_WIDTH-1:0] prf_num_t;  // physical tag
    typedef logic [31:0]              word_t;     // data, pc, immediate
    typedef logic [IQ_IDX_WIDTH-1:0]  iq_idx_t;   // queue slot

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLL  = 4'd6,   // shift amount from opb[4:0]
        ALU_SRL  = 4'd7,
        ALU_SRA  = 4'd8,
        ALU_SLT  = 4'd9,
        ALU_SLTU = 4'd10,
        ALU_LUI  = 4'd11   // opb << 16
    } alu_op_e;

    // renamed ALU micro-op as it sits in the queue
    // opa = r_rs1 ? rs1 value : 0
    // opb = r_rs2 ? rs2 value : imm
    typedef struct packed {
        word_t    pc;
        prf_num_t prf_rs1;
        prf_num_t prf_rs2;
        logic     r_rs1;     // reads rs1
        logic     r_rs2;     // reads rs2, else imm
        prf_num_t prf_rd;
        logic     wen_rd;    // writes prf_rd
        word_t    imm;
        alu_op_e  alu_op;
    } alu_uop_t;

    // writeback broadcast, also the wakeup bus
    typedef struct packed {
        logic     valid;
        prf_num_t tag;
        word_t    data;
    } wb_bus_t;

    // true when either writeback bus carries tag this cycle
    function automatic logic wb_hit(
        input wb_bus_t  a,
        input wb_bus_t  b,
        input prf_num_t tag
    );
        logic hit_a;
        logic hit_b;
        hit_a = a.valid && (a.tag == tag);
        hit_b = b.valid && (b.tag == tag);
        return hit_a || hit_b;
    endfunction

endpackage

/* prf_read.sv */
module prf_read (
    input  logic              clk,
    input  logic              rst,
    // dispatch side, busy lookup
    input  logic              disp_valid_i,
    input  ooo_pkg::prf_num_t disp_rs1_i,
    input  ooo_pkg::prf_num_t disp_rs2_i,
    input  ooo_pkg::prf_num_t disp_rd_i,
    input  logic              disp_wen_rd_i,
    output logic              src1_rdy_o,
    output logic              src2_rdy_o,
    // issue side
    input  logic              issue_valid_i,
    input  ooo_pkg::alu_uop_t issue_uop_i,
    // writeback
    input  ooo_pkg::wb_bus_t  wb_a_i,
    input  ooo_pkg::wb_bus_t  wb_b_i,
    // to execute
    output logic              ex_valid_o,
    output ooo_pkg::alu_uop_t ex_uop_o,
    output ooo_pkg::word_t    opa_o,
    output ooo_pkg::word_t    opb_o
);
    import ooo_pkg::*;

    word_t              prf_q [PRF_NUM];
    logic [PRF_NUM-1:0] busy_q;

    logic               ex_valid_q;
    alu_uop_t           ex_uop_q;
    word_t              opa_q;
    word_t              opb_q;

    // ready if not busy, or written back this very cycle
    assign src1_rdy_o = !busy_q[disp_rs1_i] || wb_hit(wb_a_i, wb_b_i, disp_rs1_i);
    assign src2_rdy_o = !busy_q[disp_rs2_i] || wb_hit(wb_a_i, wb_b_i, disp_rs2_i);

    // register file, ext port written last so it wins a tag clash
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PRF_NUM; i++) begin
                prf_q[i] <= '0;
            end
        end else begin
            if (wb_a_i.valid) begin
                prf_q[wb_a_i.tag] <= wb_a_i.data;
            end
            if (wb_b_i.valid) begin
                prf_q[wb_b_i.tag] <= wb_b_i.data;
            end
        end
    end

    // busy table
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= '0;
        end else begin
            if (wb_a_i.valid) busy_q[wb_a_i.tag] <= 1'b0;
            if (wb_b_i.valid) busy_q[wb_b_i.tag] <= 1'b0;
            if (disp_valid_i && disp_wen_rd_i) begin
                busy_q[disp_rd_i] <= 1'b1;   // new producer wins
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid_q <= 1'b0;
        end else begin
            ex_valid_q <= issue_valid_i;
        end
    end

    // operand read and select
    always_ff @(posedge clk) begin
        if (issue_valid_i) begin
            ex_uop_q <= issue_uop_i;
            opa_q    <= issue_uop_i.r_rs1 ? prf_q[issue_uop_i.prf_rs1] : '0;
            opb_q    <= issue_uop_i.r_rs2 ? prf_q[issue_uop_i.prf_rs2] : issue_uop_i.imm;
        end
    end

    assign ex_valid_o = ex_valid_q;
    assign ex_uop_o   = ex_uop_q;
    assign opa_o      = opa_q;
    assign opb_o      = opb_q;

endmodule

/* tb_alu_issue.sv */
module tb_alu_issue;
    import ooo_pkg::*;

    localparam word_t PC_BASE  = 32'h0000_1000;
    localparam int    MAX_EXP  = 256;
    localparam int    WAIT_MAX = 400;   // cycles

    typedef enum logic [1:0] {
        K_EXT,    // external writeback of tag and value
        K_DISP,   // micro-op that must be accepted
        K_DROP,   // micro-op sent while the queue is full
        K_SYNC    // drain all outstanding writebacks
    } kind_e;

    typedef struct {
        kind_e    kind;
        wb_bus_t  ext;
        alu_uop_t uop;
        word_t    exp;       // expected result of the micro-op
    } step_t;

    logic     clk;
    logic     rst;
    logic     dispatch_valid;
    alu_uop_t dispatch_uop;
    wb_bus_t  ext_wb;
    logic     iq_full;
    wb_bus_t  wb;
    word_t    wb_pc;

    step_t    steps[$];
    word_t    ref_prf [PRF_NUM];   // register values in program order
    logic     exp_pend [MAX_EXP];
    prf_num_t exp_tag  [MAX_EXP];
    word_t    exp_data [MAX_EXP];
    int       outstanding;
    logic [31:0] lfsr_q;

    alu_issue_top u_dut (
        .clk              (clk),
        .rst              (rst),
        .dispatch_valid_i (dispatch_valid),
        .dispatch_uop_i   (dispatch_uop),
        .ext_wb_i         (ext_wb),
        .iq_full_o        (iq_full),
        .wb_o             (wb),
        .wb_pc_o          (wb_pc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            fail_now($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_tag(input string name, input prf_num_t exp, input prf_num_t act);
        if (exp !== act) begin
            fail_now($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            fail_now($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic rand_word(output word_t w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            w = {w[30:0], lfsr_q[0]};
        end
    endtask

    // reference ALU from the operation rules
    function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b);
        logic [4:0] amt;
        amt = b[4:0];
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_NOR:  return ~(a | b);
            ALU_SLL:  return a << amt;
            ALU_SRL:  return a >> amt;
            ALU_SRA:  return word_t'($signed(a) >>> amt);
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_LUI:  return b << 16;
            default:  return '0;
        endcase
    endfunction

    task automatic add_ext(input prf_num_t tag);
        step_t s;
        s = '{kind: K_EXT, ext: '0, uop: '0, exp: '0};
        s.ext.valid = 1'b1;
        s.ext.tag   = tag;
        rand_word(s.ext.data);
        ref_prf[tag] = s.ext.data;
        steps.push_back(s);
    endtask

    task automatic add_op(input alu_op_e op, input prf_num_t rs1, input logic r1,
                          input prf_num_t rs2, input logic r2, input prf_num_t rd,
                          input logic wen, input word_t imm, input logic drop);
        step_t s;
        word_t a;
        word_t b;
        s = '{kind: (drop ? K_DROP : K_DISP), ext: '0, uop: '0, exp: '0};
        s.uop.pc      = PC_BASE + word_t'(4 * steps.size());
        s.uop.prf_rs1 = rs1;
        s.uop.prf_rs2 = rs2;
        s.uop.r_rs1   = r1;
        s.uop.r_rs2   = r2;
        s.uop.prf_rd  = rd;
        s.uop.wen_rd  = wen;
        s.uop.imm     = imm;
        s.uop.alu_op  = op;
        a = r1 ? ref_prf[rs1] : '0;
        b = r2 ? ref_prf[rs2] : imm;
        s.exp = alu_model(op, a, b);
        if (wen && !drop) begin
            ref_prf[rd] = s.exp;
        end
        steps.push_back(s);
    endtask

    task automatic add_sync();
        step_t s;
        s = '{kind: K_SYNC, ext: '0, uop: '0, exp: '0};
        steps.push_back(s);
    endtask

    task automatic build_table();
        alu_op_e ops[12];
        alu_op_e cons[8];
        ops  = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
                 ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_LUI};
        cons = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLTU, ALU_SLT};
        for (int t = 1; t <= 4; t++) begin
            add_ext(prf_num_t'(t));
        end
        // register forms of every op
        for (int i = 0; i < 12; i++) begin
            add_op(ops[i], 6'd1, 1'b1, 6'd2, 1'b1, prf_num_t'(10 + i), 1'b1, '0, 1'b0);
        end
        // immediate forms, and ops without rs1
        add_op(ALU_ADD,  6'd3, 1'b1, 6'd0, 1'b0, 6'd22, 1'b1, 32'hffff_fff0, 1'b0);
        add_op(ALU_SLL,  6'd4, 1'b1, 6'd0, 1'b0, 6'd23, 1'b1, 32'd5, 1'b0);
        add_op(ALU_SRA,  6'd2, 1'b1, 6'd0, 1'b0, 6'd24, 1'b1, 32'd13, 1'b0);
        add_op(ALU_SLTU, 6'd1, 1'b1, 6'd0, 1'b0, 6'd25, 1'b1, 32'h8000_0000, 1'b0);
        add_op(ALU_LUI,  6'd0, 1'b0, 6'd0, 1'b0, 6'd26, 1'b1, 32'h0000_1234, 1'b0);
        add_op(ALU_OR,   6'd0, 1'b0, 6'd0, 1'b0, 6'd27, 1'b1, 32'h00a5_5a00, 1'b0);
        // dependent chain, woken by the ALU writeback
        add_op(ALU_ADD,  6'd1,  1'b1, 6'd0,  1'b0, 6'd30, 1'b1, 32'd1, 1'b0);
        add_op(ALU_ADD,  6'd30, 1'b1, 6'd2,  1'b1, 6'd31, 1'b1, '0, 1'b0);
        add_op(ALU_XOR,  6'd31, 1'b1, 6'd1,  1'b1, 6'd32, 1'b1, '0, 1'b0);
        add_op(ALU_SUB,  6'd32, 1'b1, 6'd31, 1'b1, 6'd33, 1'b1, '0, 1'b0);
        // no destination write, must stay off the bus
        add_op(ALU_ADD,  6'd1,  1'b1, 6'd2,  1'b1, 6'd34, 1'b0, '0, 1'b0);
        add_sync();
        // three-op producer keeps tag 42 busy while eight readers fill the queue
        add_op(ALU_ADD,  6'd3,  1'b1, 6'd0,  1'b0, 6'd40, 1'b1, 32'd7, 1'b0);
        add_op(ALU_SLL,  6'd40, 1'b1, 6'd0,  1'b0, 6'd41, 1'b1, 32'd3, 1'b0);
        add_op(ALU_ADD,  6'd41, 1'b1, 6'd4,  1'b1, 6'd42, 1'b1, '0, 1'b0);
        for (int i = 0; i < 8; i++) begin
            add_op(cons[i], 6'd42, 1'b1, 6'd1, 1'b1, prf_num_t'(43 + i), 1'b1, '0, 1'b0);
        end
        add_op(ALU_ADD,  6'd1,  1'b1, 6'd2,  1'b1, 6'd51, 1'b1, '0, 1'b1);   // dropped
        add_sync();
    endtask

    task automatic drive_idle();
        dispatch_valid <= 1'b0;
        ext_wb         <= '0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (outstanding != 0) begin
            @(negedge clk);
            n++;
            if (n > WAIT_MAX) begin
                fail_now($sformatf("timeout: %0d writebacks never arrived", outstanding));
            end
        end
    endtask

    task automatic apply_step(input int idx, input step_t s);
        int tries;
        tries = 0;
        case (s.kind)
            K_EXT: begin
                @(posedge clk);
                dispatch_valid <= 1'b0;
                ext_wb         <= s.ext;
            end
            K_DISP: begin
                forever begin
                    @(posedge clk);
                    ext_wb         <= '0;
                    dispatch_valid <= 1'b1;
                    dispatch_uop   <= s.uop;
                    @(negedge clk);
                    if (!iq_full) break;   // taken at the coming edge
                    tries++;
                    if (tries > WAIT_MAX) begin
                        fail_now("timeout: issue queue never left the full state");
                    end
                end
                if (s.uop.wen_rd) begin
                    exp_pend[idx] = 1'b1;
                    exp_tag[idx]  = s.uop.prf_rd;
                    exp_data[idx] = s.exp;
                    outstanding++;
                end
            end
            K_DROP: begin
                @(posedge clk);
                ext_wb         <= '0;
                dispatch_valid <= 1'b1;
                dispatch_uop   <= s.uop;
                @(negedge clk);
                check_flag("iq_full_at_drop", 1'b1, iq_full);
            end
            default: begin
                @(posedge clk);
                drive_idle();
                wait_drain();
            end
        endcase
    endtask

    // writeback monitor, sampled mid-cycle
    always @(negedge clk) begin
        int idx;
        if (!rst && wb.valid) begin
            idx = int'((wb_pc - PC_BASE) >> 2);
            if (idx < 0 || idx >= MAX_EXP || !exp_pend[idx]) begin
                fail_now($sformatf("writeback to tag %0d with pc %h was not expected",
                                   wb.tag, wb_pc));
            end
            check_tag($sformatf("wb_tag_pc_%h", wb_pc), exp_tag[idx], wb.tag);
            check_word($sformatf("wb_data_tag_%0d", wb.tag), exp_data[idx], wb.data);
            exp_pend[idx] = 1'b0;
            outstanding--;
        end
    end

    initial begin
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_uop   = '0;
        ext_wb         = '0;
        outstanding    = 0;
        lfsr_q         = 32'ha63a;
        for (int i = 0; i < PRF_NUM; i++) begin
            ref_prf[i] = '0;
        end
        for (int i = 0; i < MAX_EXP; i++) begin
            exp_pend[i] = 1'b0;
        end
        build_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < steps.size(); i++) begin
            apply_step(i, steps[i]);
        end
        @(posedge clk);
        drive_idle();
        wait_drain();
        repeat (20) @(posedge clk);   // room for a stray writeback to show up
        check_flag("iq_full_at_end", 1'b0, iq_full);
        $display(">>> PASS");
        $finish;
    end

endmodule
